// ==== src/rv32_macros.svh ====
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

`define XLEN         32            // Data and address width
`define REG_ADDR_W   5             // Register index width
`define RESET_VECTOR 32'h0000_0000 // First fetch address

// Major opcodes
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_ALU_IMM 7'b0010011
`define OP_ALU_REG 7'b0110011

// ALU funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101 // SRL or SRA by funct7 bit 5
`define F3_OR   3'b110
`define F3_AND  3'b111

// Branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Access size in funct3 bits 1:0
`define F3_SIZE_B 2'b00
`define F3_SIZE_H 2'b01
`define F3_SIZE_W 2'b10

`endif

// ==== src/rv32_pkg.sv ====
`include "rv32_macros.svh"

package rv32_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm_11_0;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_4_0;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef struct packed {
        logic                   lui;     // One-hot class flags
        logic                   auipc;
        logic                   jal;
        logic                   jalr;
        logic                   branch;
        logic                   load;
        logic                   store;
        logic                   alu_imm;
        logic                   alu_reg;
        logic [2:0]             funct3;
        logic                   alt;     // funct7 bit 5
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] sum;         // rs1 plus second operand
        logic             take_branch;
    } alu_out_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wrdata;
        logic [3:0]       bytesel;
        logic             wren;
    } mem_req_t;

endpackage

// ==== src/rv32_decoder.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_decoder import rv32_pkg::*; (
    input  instr_t           instr,
    output ctrl_t            ctrl,
    output logic [`XLEN-1:0] imm
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    ////////////////////////////////////////////////////////////////////
    // Instruction class
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = instr.r_fmt.funct3;
        ctrl.alt    = instr.r_fmt.funct7[5]; // SUB and SRA select
        ctrl.rd     = instr.r_fmt.rd;
        ctrl.rs1    = instr.r_fmt.rs1;
        ctrl.rs2    = instr.r_fmt.rs2;

        case (instr.r_fmt.opcode)
            `OP_LUI:     ctrl.lui     = 1'b1;
            `OP_AUIPC:   ctrl.auipc   = 1'b1;
            `OP_JAL:     ctrl.jal     = 1'b1;
            `OP_JALR:    ctrl.jalr    = 1'b1;
            `OP_BRANCH:  ctrl.branch  = 1'b1;
            `OP_LOAD:    ctrl.load    = 1'b1;
            `OP_STORE:   ctrl.store   = 1'b1;
            `OP_ALU_IMM: ctrl.alu_imm = 1'b1;
            `OP_ALU_REG: ctrl.alu_reg = 1'b1;
            default: begin
                // FENCE, SYSTEM and unknown opcodes retire as no-ops
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};

    assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}},
                    instr.s_fmt.imm_11_5,
                    instr.s_fmt.imm_4_0};

    assign imm_b = {{19{instr.b_fmt.imm_12}},
                    instr.b_fmt.imm_12,
                    instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5,
                    instr.b_fmt.imm_4_1,
                    1'b0};

    assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};

    assign imm_j = {{11{instr.j_fmt.imm_20}},
                    instr.j_fmt.imm_20,
                    instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11,
                    instr.j_fmt.imm_10_1,
                    1'b0};

    always_comb begin
        if (ctrl.store)
            imm = imm_s;
        else if (ctrl.branch)
            imm = imm_b;
        else if (ctrl.lui || ctrl.auipc)
            imm = imm_u;
        else if (ctrl.jal)
            imm = imm_j;
        else
            imm = imm_i; // JALR, loads, ALU immediate
    end

endmodule

// ==== src/rv32_regfile.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_regfile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   we,
    input  logic [`XLEN-1:0]       rd_data,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);

    logic [`XLEN-1:0] regs [1 << `REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= rd_data; // x0 never written
        end
    end

    // Reads of x0 bypass the array
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv32_alu.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_alu import rv32_pkg::*; (
    input  ctrl_t            ctrl,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    output alu_out_t         alu_out
);

    logic [`XLEN-1:0] op_b;
    logic [`XLEN:0]   diff;     // Carry out in top bit
    logic             is_eq;
    logic             is_lt;
    logic             is_ltu;
    logic [4:0]       shamt;
    logic             sr_fill;
    logic signed [`XLEN:0] sr_wide;
    logic [`XLEN-1:0] sll_res;

    assign op_b = (ctrl.alu_reg || ctrl.branch) ? rs2_data : imm;

    ////////////////////////////////////////////////////////////////////
    // Adder and compare
    ////////////////////////////////////////////////////////////////////
    assign alu_out.sum = rs1_data + op_b;
    assign diff        = {1'b0, rs1_data} - {1'b0, op_b};

    assign is_eq  = (diff[`XLEN-1:0] == '0);
    assign is_ltu = diff[`XLEN];    // Borrow
    assign is_lt  = (rs1_data[`XLEN-1] ^ op_b[`XLEN-1]) ? rs1_data[`XLEN-1] : diff[`XLEN];

    ////////////////////////////////////////////////////////////////////
    // Shifter
    ////////////////////////////////////////////////////////////////////
    assign shamt   = op_b[4:0];     // imm[4:0] is the shamt field
    assign sr_fill = ctrl.alt & rs1_data[`XLEN-1];
    assign sll_res = rs1_data << shamt;
    assign sr_wide = $signed({sr_fill, rs1_data}) >>> shamt;

    always_comb begin
        case (ctrl.funct3)
            `F3_ADD:  alu_out.result = (ctrl.alu_reg && ctrl.alt) ? diff[`XLEN-1:0]
                                                                 : alu_out.sum;
            `F3_SLL:  alu_out.result = sll_res;
            `F3_SLT:  alu_out.result = {{(`XLEN-1){1'b0}}, is_lt};
            `F3_SLTU: alu_out.result = {{(`XLEN-1){1'b0}}, is_ltu};
            `F3_XOR:  alu_out.result = rs1_data ^ op_b;
            `F3_SR:   alu_out.result = sr_wide[`XLEN-1:0];
            `F3_OR:   alu_out.result = rs1_data | op_b;
            default:  alu_out.result = rs1_data & op_b; // AND
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        alu_out.take_branch = 1'b0;
        if (ctrl.branch) begin
            case (ctrl.funct3)
                `F3_BEQ:  alu_out.take_branch = is_eq;
                `F3_BNE:  alu_out.take_branch = !is_eq;
                `F3_BLT:  alu_out.take_branch = is_lt;
                `F3_BGE:  alu_out.take_branch = !is_lt;
                `F3_BLTU: alu_out.take_branch = is_ltu;
                `F3_BGEU: alu_out.take_branch = !is_ltu;
                default:  alu_out.take_branch = 1'b0;
            endcase
        end
    end

endmodule

// ==== src/rv32_lsu.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_lsu (
    input  logic [2:0]       funct3,
    input  logic [1:0]       byte_off,
    input  logic [`XLEN-1:0] store_data,
    input  logic [`XLEN-1:0] rddata,
    output logic [`XLEN-1:0] wrdata,
    output logic [3:0]       bytesel,
    output logic [`XLEN-1:0] load_data
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    ////////////////////////////////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        case (funct3[1:0])
            `F3_SIZE_B: begin
                wrdata  = {4{store_data[7:0]}};  // Byte in every lane
                bytesel = 4'b0001 << byte_off;
            end
            `F3_SIZE_H: begin
                wrdata  = {2{store_data[15:0]}};
                bytesel = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wrdata  = store_data;            // Word, bits 1:0 ignored
                bytesel = 4'b1111;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Load lanes
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        case (byte_off)
            2'd0:    lane_b = rddata[7:0];
            2'd1:    lane_b = rddata[15:8];
            2'd2:    lane_b = rddata[23:16];
            default: lane_b = rddata[31:24];
        endcase
    end

    assign lane_h = byte_off[1] ? rddata[31:16] : rddata[15:0];

    // funct3 bit 2 selects zero extension
    always_comb begin
        case (funct3[1:0])
            `F3_SIZE_B: load_data = funct3[2] ? {24'b0, lane_b} : {{24{lane_b[7]}}, lane_b};
            `F3_SIZE_H: load_data = funct3[2] ? {16'b0, lane_h} : {{16{lane_h[15]}}, lane_h};
            default:    load_data = rddata;
        endcase
    end

endmodule

// ==== src/rv32_core.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_core import rv32_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] bus_addr,
    output logic [`XLEN-1:0] bus_wrdata,
    output logic [3:0]       bus_bytesel,
    output logic             bus_wren,
    output logic             bus_strobe,
    input  logic             bus_wait,
    input  logic [`XLEN-1:0] bus_rddata
);

    localparam logic [1:0] FETCH = 2'd0;
    localparam logic [1:0] LOAD  = 2'd1;
    localparam logic [1:0] STORE = 2'd2;

    logic [1:0]       state;
    logic [`XLEN-1:0] pc;
    instr_t           instr_q;     // Held for the data access
    instr_t           cur_instr;
    mem_req_t         req;
    logic             done;        // Access completes at this edge

    ctrl_t            ctrl;
    alu_out_t         alu_out;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] lsu_wrdata;
    logic [3:0]       lsu_bytesel;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] pc_plus_imm;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] wb_data;
    logic             writes_rd;
    logic             reg_we;

    function automatic mem_req_t fetch_req(input logic [`XLEN-1:0] addr);
        fetch_req = '{addr: {addr[`XLEN-1:2], 2'b00}, wrdata: '0, bytesel: 4'b1111,
                      wren: 1'b0};
    endfunction

    assign bus_addr    = req.addr;
    assign bus_wrdata  = req.wrdata;
    assign bus_bytesel = req.bytesel;
    assign bus_wren    = req.wren;
    assign bus_strobe  = 1'b1;         // Requests run back to back

    assign done      = !bus_wait;
    assign cur_instr = (state == FETCH) ? instr_t'(bus_rddata) : instr_q;

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////
    rv32_decoder u_decoder (.instr(cur_instr), .ctrl(ctrl), .imm(imm));

    rv32_regfile u_regfile (
        .clk(clk), .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd), .we(reg_we),
        .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv32_alu u_alu (
        .ctrl(ctrl), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_out(alu_out)
    );

    rv32_lsu u_lsu (
        .funct3(ctrl.funct3), .byte_off(alu_out.sum[1:0]), .store_data(rs2_data),
        .rddata(bus_rddata), .wrdata(lsu_wrdata), .bytesel(lsu_bytesel),
        .load_data(load_data)
    );

    assign pc_plus4    = pc + `XLEN'd4;
    assign pc_plus_imm = pc + imm;    // AUIPC, JAL and branch target

    always_comb begin
        if (ctrl.jal || alu_out.take_branch)
            next_pc = pc_plus_imm;
        else if (ctrl.jalr)
            next_pc = {alu_out.sum[`XLEN-1:1], 1'b0};
        else
            next_pc = pc_plus4;
    end

    always_comb begin
        if (ctrl.lui)
            wb_data = imm;
        else if (ctrl.auipc)
            wb_data = pc_plus_imm;
        else if (ctrl.jal || ctrl.jalr)
            wb_data = pc_plus4;       // Link value
        else if (ctrl.load)
            wb_data = load_data;
        else
            wb_data = alu_out.result;
    end

    assign writes_rd = ctrl.lui || ctrl.auipc || ctrl.jal || ctrl.jalr ||
                       ctrl.alu_imm || ctrl.alu_reg;
    assign reg_we    = done && ((state == FETCH && writes_rd) || state == LOAD);

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == FETCH && done) begin
            instr_q <= bus_rddata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= FETCH;
            pc     <= `RESET_VECTOR;
            req    <= fetch_req(`RESET_VECTOR); // First fetch right away
        end else if (done) begin
            if (state == FETCH && (ctrl.load || ctrl.store)) begin
                state <= ctrl.load ? LOAD : STORE;
                req   <= '{addr: alu_out.sum, wrdata: lsu_wrdata, bytesel: lsu_bytesel,
                           wren: ctrl.store};
            end else if (state == FETCH) begin
                pc  <= {next_pc[`XLEN-1:2], 2'b00};
                req <= fetch_req(next_pc);
            end else begin
                state <= FETCH;          // Data access finished
                pc    <= pc_plus4;
                req   <= fetch_req(pc_plus4);
            end
        end
    end

endmodule

// ==== tests/rv32_core_checker.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_core_checker (
    input logic             clk,
    input logic             reset,
    input logic [`XLEN-1:0] bus_addr,
    input logic [`XLEN-1:0] bus_wrdata,
    input logic [3:0]       bus_bytesel,
    input logic             bus_wren,
    input logic             bus_strobe,
    input logic             bus_wait,
    input logic [1:0]       state
);

    int   fail_count = 0;
    logic is_fetch;

    assign is_fetch = (state == 2'd0); // FETCH state of the core

    //////////////////////////////////////////////////////////////////////
    // Request after reset
    //////////////////////////////////////////////////////////////////////
    reset_fetch: assert property (@(posedge clk)
        $fell(reset) |-> bus_strobe && bus_addr == `RESET_VECTOR && !bus_wren)
    else begin
        fail_count++;
        $error("First request after reset is not a read of the reset vector");
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////
    hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && bus_wait |=> bus_strobe && $stable(bus_addr) && $stable(bus_wrdata)
                                   && $stable(bus_bytesel) && $stable(bus_wren))
    else begin
        fail_count++;
        $error("Bus request changed while bus_wait was high");
    end

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && is_fetch |-> bus_addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("Fetch address is not word aligned");
    end

    //////////////////////////////////////////////////////////////////////
    // Write lanes
    //////////////////////////////////////////////////////////////////////
    byte_lane: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && bus_wren && $onehot(bus_bytesel)
            |-> bus_bytesel == (4'b0001 << bus_addr[1:0]))
    else begin
        fail_count++;
        $error("Byte write lane does not match the address");
    end

    half_lane: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && bus_wren && $countones(bus_bytesel) == 2
            |-> bus_bytesel == (bus_addr[1] ? 4'b1100 : 4'b0011))
    else begin
        fail_count++;
        $error("Halfword write lanes do not match the address");
    end

endmodule

bind rv32_core rv32_core_checker u_checker (
    .clk(clk),
    .reset(reset),
    .bus_addr(bus_addr),
    .bus_wrdata(bus_wrdata),
    .bus_bytesel(bus_bytesel),
    .bus_wren(bus_wren),
    .bus_strobe(bus_strobe),
    .bus_wait(bus_wait),
    .state(state)
);

// ==== tests/rv32_core_tb.sv ====
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_core_tb;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  sel;
        logic [31:0] data;   // Only the selected lanes
    } write_t;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic [`XLEN-1:0] bus_addr;
    logic [`XLEN-1:0] bus_wrdata;
    logic [3:0]       bus_bytesel;
    logic             bus_wren;
    logic             bus_strobe;
    logic             bus_wait = 1'b1;
    logic [`XLEN-1:0] bus_rddata = '0;

    logic [31:0] mem [256];
    write_t      exp_q [$];
    logic [31:0] rnd = 32'h54b75832;
    logic [1:0]  wait_left = '0;
    logic        new_access = 1'b1;
    int          pc_idx = 0;
    int          res_k = 0;        // Next slot in the result area
    int          writes_done = 0;
    int          total_writes;
    int          cycles;

    rv32_core rv32_core_i (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error: %s is %h, expected %h", name, got, exp);
        abort_run();
    endtask

    ////////////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OP_ALU_REG};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////////////
    task automatic emit(input logic [31:0] word);
        mem[pc_idx] = word;
        pc_idx++;
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [3:0] sel,
                                input logic [31:0] data);
        write_t w;
        w.addr = addr;
        w.sel  = sel;
        w.data = data;
        exp_q.push_back(w);
    endtask

    task automatic emit_result(input logic [4:0] rs, input logic [31:0] value);
        emit(enc_s({1'b0, `F3_SIZE_W}, 5'd31, rs, res_k * 4)); // SW into result area
        expect_write(32'h200 + res_k * 4, 4'hF, value);
        res_k++;
    endtask

    task automatic emit_alu_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rs1,
                                input logic [4:0] rs2, input logic [31:0] value);
        emit(enc_r(f3, alt, 5'd3, rs1, rs2));
        emit_result(5'd3, value);
    endtask

    // Marker in x20 tells which path ran
    task automatic emit_branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input logic taken);
        logic [31:0] marker;
        marker = 32'h100 + res_k * 2;
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd20, 5'd0, marker));
        emit(enc_b(f3, rs1, rs2, 32'd8));
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd20, 5'd0, marker + 1));
        emit_result(5'd20, taken ? marker : marker + 1);
    endtask

    task automatic emit_load_case(input logic [2:0] f3, input logic [31:0] off,
                                  input logic [31:0] value);
        emit(enc_i(`OP_LOAD, f3, 5'd30, 5'd25, off));
        emit_result(5'd30, value);
    endtask

    task automatic load_program();
        logic [31:0] here;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA5A5_0000 | (i << 2);
        end
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd31, 5'd0, 32'h200)); // Result base
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd1, 5'd0, 32'd100));
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd2, 5'd0, -32'sd7));
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd5, 5'd0, 32'd3));
        emit_result(5'd2, 32'hFFFF_FFF9);
        emit_alu_reg(`F3_ADD, 1'b0, 5'd1, 5'd2, 32'h0000_005D);
        emit_alu_reg(`F3_ADD, 1'b1, 5'd2, 5'd1, 32'hFFFF_FF95); // SUB
        emit_alu_reg(`F3_SLL, 1'b0, 5'd1, 5'd5, 32'h0000_0320);
        emit_alu_reg(`F3_SR, 1'b0, 5'd2, 5'd5, 32'h1FFF_FFFF);
        emit_alu_reg(`F3_SR, 1'b1, 5'd2, 5'd5, 32'hFFFF_FFFF);  // SRA
        emit_alu_reg(`F3_SLT, 1'b0, 5'd2, 5'd1, 32'd1);
        emit_alu_reg(`F3_SLTU, 1'b0, 5'd2, 5'd1, 32'd0);
        emit_alu_reg(`F3_XOR, 1'b0, 5'd1, 5'd2, 32'hFFFF_FF9D);
        emit_alu_reg(`F3_OR, 1'b0, 5'd1, 5'd2, 32'hFFFF_FFFD);
        emit_alu_reg(`F3_AND, 1'b0, 5'd1, 5'd2, 32'h0000_0060);
        emit(enc_u(`OP_LUI, 5'd3, 20'hABCDE));
        emit_result(5'd3, 32'hABCD_E000);
        here = pc_idx * 4;
        emit(enc_u(`OP_AUIPC, 5'd3, 20'h00001));
        emit_result(5'd3, here + 32'h1000);

        // x1 = 100, x2 = -7
        emit_branch_case(`F3_BEQ, 5'd1, 5'd1, 1'b1);
        emit_branch_case(`F3_BEQ, 5'd1, 5'd2, 1'b0);
        emit_branch_case(`F3_BNE, 5'd1, 5'd2, 1'b1);
        emit_branch_case(`F3_BNE, 5'd1, 5'd1, 1'b0);
        emit_branch_case(`F3_BLT, 5'd2, 5'd1, 1'b1);
        emit_branch_case(`F3_BLT, 5'd1, 5'd2, 1'b0);
        emit_branch_case(`F3_BGE, 5'd1, 5'd2, 1'b1);
        emit_branch_case(`F3_BGE, 5'd2, 5'd1, 1'b0);
        emit_branch_case(`F3_BLTU, 5'd1, 5'd2, 1'b1);
        emit_branch_case(`F3_BLTU, 5'd2, 5'd1, 1'b0);
        emit_branch_case(`F3_BGEU, 5'd2, 5'd1, 1'b1);
        emit_branch_case(`F3_BGEU, 5'd1, 5'd2, 1'b0);

        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd22, 5'd0, 32'h55));
        here = pc_idx * 4 + 4;      // JAL link
        emit(enc_j(5'd21, 32'd8));
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd22, 5'd0, 32'h66));
        emit_result(5'd21, here);
        emit_result(5'd22, 32'h55);
        here = pc_idx * 4;
        emit(enc_u(`OP_AUIPC, 5'd23, 20'h0));
        emit(enc_i(`OP_JALR, 3'b000, 5'd24, 5'd23, 32'd17)); // Target bit 0 cleared
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd22, 5'd0, 32'h77));
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd22, 5'd0, 32'h78));
        emit_result(5'd24, here + 8);
        emit_result(5'd22, 32'h55);

        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd25, 5'd0, 32'h300)); // Scratch base
        emit(enc_u(`OP_LUI, 5'd26, 20'h87654));
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd26, 5'd26, 32'h321));
        emit(enc_s({1'b0, `F3_SIZE_W}, 5'd25, 5'd26, 32'd0));
        expect_write(32'h300, 4'hF, 32'h8765_4321);
        emit(enc_s({1'b0, `F3_SIZE_W}, 5'd25, 5'd26, 32'd4));
        expect_write(32'h304, 4'hF, 32'h8765_4321);
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd27, 5'd0, 32'hAB));
        emit(enc_s({1'b0, `F3_SIZE_B}, 5'd25, 5'd27, 32'd1));
        expect_write(32'h301, 4'b0010, 32'h0000_AB00);
        emit(enc_i(`OP_ALU_IMM, `F3_ADD, 5'd27, 5'd0, 32'h7CD));
        emit(enc_s({1'b0, `F3_SIZE_H}, 5'd25, 5'd27, 32'd2));
        expect_write(32'h302, 4'b1100, 32'h07CD_0000);
        emit_load_case({1'b0, `F3_SIZE_W}, 32'd0, 32'h07CD_AB21);
        emit_load_case({1'b0, `F3_SIZE_B}, 32'd7, 32'hFFFF_FF87);
        emit_load_case({1'b1, `F3_SIZE_B}, 32'd7, 32'h0000_0087);
        emit_load_case({1'b0, `F3_SIZE_H}, 32'd6, 32'hFFFF_8765);
        emit_load_case({1'b1, `F3_SIZE_H}, 32'd6, 32'h0000_8765);
        emit_load_case({1'b0, `F3_SIZE_B}, 32'd4, 32'h0000_0021);
        emit(enc_j(5'd0, 32'd0));   // Park here
    endtask

    ////////////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////////////
    task automatic check_write();
        write_t exp;
        if (exp_q.size() == 0) begin
            $display("Unexpected write to address %h after the last expected store", bus_addr);
            abort_run();
        end else begin
            exp = exp_q.pop_front();
            assert (bus_addr == exp.addr)
                else report_mismatch("bus_addr", bus_addr, exp.addr);
            assert (bus_bytesel == exp.sel)
                else report_mismatch("bus_bytesel", {28'b0, bus_bytesel}, {28'b0, exp.sel});
            assert ((bus_wrdata & lane_mask(bus_bytesel)) == exp.data)
                else report_mismatch("bus_wrdata", bus_wrdata & lane_mask(bus_bytesel),
                                     exp.data);
            for (int b = 0; b < 4; b++) begin
                if (bus_bytesel[b])
                    mem[bus_addr[9:2]][8*b +: 8] = bus_wrdata[8*b +: 8];
            end
            writes_done++;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            bus_wait   = 1'b1;      // Nothing completes in reset
            new_access = 1'b1;
        end else if (bus_strobe) begin
            if (new_access) begin
                rnd        = xorshift32(rnd);
                wait_left  = rnd[1:0]; // 0 to 3 wait cycles
                new_access = 1'b0;
            end
            if (wait_left != 2'd0) begin
                bus_wait  = 1'b1;
                wait_left = wait_left - 2'd1;
            end else begin
                bus_wait   = 1'b0;  // Completes at the next rising edge
                bus_rddata = mem[bus_addr[9:2]];
                if (bus_wren)
                    check_write();
                new_access = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////
    initial begin
        load_program();
        total_writes = exp_q.size();
        repeat (8) @(negedge clk);
        reset  <= 1'b0;
        cycles = 0;
        while (writes_done < total_writes) begin
            if (cycles > 5000) begin
                $display("Timeout waiting for the result stores of the program");
                abort_run();
            end else if (rv32_core_i.u_checker.fail_count != 0) begin
                $display("Bus protocol assertion failed during the program");
                abort_run();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        @(negedge clk);
        if (rv32_core_i.u_checker.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Bus protocol assertion failed at the end of the program");
            abort_run();
        end
    end

endmodule

// ==== rv32_core.f ====
+incdir+src
src/rv32_pkg.sv
src/rv32_decoder.sv
src/rv32_regfile.sv
src/rv32_alu.sv
src/rv32_lsu.sv
src/rv32_core.sv
tests/rv32_core_checker.sv
tests/rv32_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the RV32I core testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f rv32_core.f \
    --top-module rv32_core_tb -o rv32_core_sim &&
./obj_dir/rv32_core_sim +verilator+error+limit+100 ||
exit 1
